//--- compile.f
hw/bpu_pkg.sv
hw/micro_btb.sv
hw/btb.sv
hw/bimodal_dir.sv
hw/return_stack.sv
hw/s2_control.sv
hw/branch_predictor.sv
dv/tb_branch_predictor.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_branch_predictor \
    -f compile.f -o sim_tb > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0

//--- dv/tb_branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_branch_predictor;
    import bpu_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int TEST_CYCLES = 80;
    localparam int MARGIN_CYCLES = 40;
    localparam int VALID_LIMIT = 8;
    // all test blocks share bits 31:21, so a jump field can reach them
    localparam logic [VADDR_W-1:0] REGION = 32'h0040_0000;

    logic clk;
    logic arst_n_i;
    logic stall_i;
    logic squash_i;
    logic [VADDR_W-1:0] squash_pc_i;
    update_t upd_i;
    pred_result_t pred_o;
    pred_result_t last_stage_pred;
    logic pred_valid_o;
    logic redirect_o;
    logic last_stage_o;

    integer seed = 8;

    branch_predictor #(
        .UBTB_DEPTH(16), .BTB_DEPTH(64), .BHT_DEPTH(128), .RAS_DEPTH(8)
    ) DUT (
        .clk(clk), .arst_n_i(arst_n_i), .stall_i(stall_i), .squash_i(squash_i),
        .squash_pc_i(squash_pc_i), .upd_i(upd_i), .pred_o(pred_o),
        .pred_valid_o(pred_valid_o), .redirect_o(redirect_o),
        .last_stage_o(last_stage_o), .last_stage_pred_o(last_stage_pred)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_stop();
        $display("Simulation FAILED");
        $fatal(1, "run stopped");
    endtask

    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("timeout: the tests did not finish in time");
        fail_stop();
    end

    task automatic check_pred(input string name, input pred_result_t got,
                              input pred_result_t exp);
        if (got !== exp) begin
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
            fail_stop();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
            fail_stop();
        end
    endtask

    // stage 1 looks at a whole block, so its size is the last slot
    function automatic pred_result_t stage1_expect(input logic [VADDR_W-1:0] start,
                                                   input logic [VADDR_W-1:0] target,
                                                   input logic taken);
        pred_result_t p;
        p = '0;
        p.en = 1'b1;
        p.start_addr = start;
        p.target = target;
        p.taken = taken;
        p.size = 2'd3;
        p.br_type = DIRECT;
        p.ras_type = NONE;
        return p;
    endfunction

    function automatic pred_result_t redirect_expect(input logic [VADDR_W-1:0] start,
                                                     input logic [VADDR_W-1:0] target,
                                                     input logic taken,
                                                     input logic [SLOT_OFF_W-1:0] size,
                                                     input br_type_e br,
                                                     input ras_type_e ras);
        pred_result_t p;
        p = stage1_expect(start, target, taken);
        p.size = size;
        p.br_type = br;
        p.ras_type = ras;
        p.redirect = 1'b1;
        return p;
    endfunction

    function automatic logic [VADDR_W-1:0] rand_block();
        logic [31:0] r;
        r = $random(seed);
        return REGION | (r & 32'h000F_FFF0);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic settle();
        #5;
    endtask

    task automatic reset_dut(input logic hold);
        next_cycle();
        arst_n_i = 1'b0;
        stall_i = hold;
        squash_i = 1'b0;
        upd_i = '0;
        repeat (4) next_cycle();
        arst_n_i = 1'b1;
        settle();
    endtask

    // pipe frozen while the tables are written
    task automatic train_entry(input logic [VADDR_W-1:0] start, input btb_entry_t ent,
                               input logic cond_taken, input logic [VADDR_W-1:0] target);
        update_t u;
        u = '0;
        u.valid = 1'b1;
        u.start_addr = start;
        u.entry = ent;
        u.cond_taken = cond_taken;
        u.taken_target = target;
        next_cycle();
        stall_i = 1'b1;
        upd_i = u;
        next_cycle();
        upd_i = '0;
    endtask

    task automatic wait_valid();
        int n;
        n = 0;
        while (!pred_valid_o) begin
            if (n == VALID_LIMIT) begin
                $display("pred_valid_o never rose after a restart");
                fail_stop();
            end
            next_cycle();
            settle();
            n++;
        end
    endtask

    task automatic restart_at(input logic [VADDR_W-1:0] addr);
        next_cycle();
        stall_i = 1'b1;
        squash_i = 1'b1;
        squash_pc_i = addr;
        next_cycle();
        squash_i = 1'b0;
        stall_i = 1'b0;
        settle();
        wait_valid();
    endtask

    task automatic reset_and_step();
        logic [VADDR_W-1:0] pc;
        reset_dut(1'b0);
        for (int i = 0; i < 4; i++) begin
            pc = RESET_PC + VADDR_W'(16 * i);
            check_bit("pred_valid_o", pred_valid_o, 1'b1);
            check_pred("pred_o", pred_o, stage1_expect(pc, pc + 32'd16, 1'b0));
            check_bit("redirect_o", redirect_o, 1'b0);
            check_bit("last_stage_o", last_stage_o, i != 0);
            if (i != 0) begin
                check_pred("last_stage_pred_o", last_stage_pred,
                           stage1_expect(pc - 32'd16, pc, 1'b0));
            end
            next_cycle();
            settle();
        end
    endtask

    task automatic squash_and_stall();
        logic [VADDR_W-1:0] s;
        s = rand_block();
        next_cycle();
        squash_i = 1'b1;
        squash_pc_i = s;
        settle();
        check_bit("pred_valid_o", pred_valid_o, 1'b0);
        check_bit("redirect_o", redirect_o, 1'b0);
        check_bit("last_stage_o", last_stage_o, 1'b0);
        next_cycle();
        squash_i = 1'b0;
        settle();
        check_bit("pred_valid_o", pred_valid_o, 1'b1);
        check_pred("pred_o", pred_o, stage1_expect(s, s + 32'd16, 1'b0));
        repeat (3) begin
            next_cycle();
            stall_i = 1'b1;
            settle();
            check_bit("pred_valid_o", pred_valid_o, 1'b0);
        end
        next_cycle();
        stall_i = 1'b0;
        settle();
        check_bit("pred_valid_o", pred_valid_o, 1'b1);
        check_pred("pred_o", pred_o, stage1_expect(s + 32'd16, s + 32'd32, 1'b0));
    endtask

    task automatic direct_jump();
        logic [VADDR_W-1:0] a;
        logic [VADDR_W-1:0] t;
        logic [31:0] r;
        btb_entry_t ent;
        reset_dut(1'b1);
        a = rand_block();
        r = $random(seed);
        t = a + 32'h200 + (r & 32'h0000_0FF0);
        ent = '0;
        ent.en = 1'b1;
        ent.tail.en = 1'b1;
        ent.tail.offset = r[1:0];
        ent.tail.br_type = DIRECT;
        ent.tail.ras_type = NONE;
        ent.tail.target.jump = t[20:1];
        ent.fth_off = 2'd3;
        // micro-BTB entry points at fall-through, so only stage 2 knows the jump
        train_entry(a, ent, 1'b0, a + 32'd16);
        restart_at(a);
        check_pred("pred_o", pred_o, stage1_expect(a, a + 32'd16, 1'b1));
        check_bit("redirect_o", redirect_o, 1'b0);
        next_cycle();
        settle();
        check_bit("redirect_o", redirect_o, 1'b1);
        check_bit("pred_valid_o", pred_valid_o, 1'b1);
        check_pred("pred_o", pred_o, redirect_expect(a, t, 1'b1, r[1:0], DIRECT, NONE));
        next_cycle();
        settle();
        check_pred("pred_o", pred_o, stage1_expect(t, t + 32'd16, 1'b0));
        check_bit("redirect_o", redirect_o, 1'b0);
        train_entry(a, ent, 1'b0, t);
        restart_at(a);
        check_pred("pred_o", pred_o, stage1_expect(a, t, 1'b1));
        next_cycle();
        settle();
        check_bit("redirect_o", redirect_o, 1'b0);
        check_bit("last_stage_o", last_stage_o, 1'b1);
        check_pred("last_stage_pred_o", last_stage_pred, stage1_expect(a, t, 1'b1));
        check_pred("pred_o", pred_o, stage1_expect(t, t + 32'd16, 1'b0));
    endtask

    task automatic cond_branch();
        logic [VADDR_W-1:0] a;
        logic [VADDR_W-1:0] tgt;
        logic [VADDR_W-1:0] fth;
        logic [BR_OFF_W-1:0] off;
        logic [SLOT_OFF_W-1:0] fo;
        logic [31:0] r;
        btb_entry_t ent;
        reset_dut(1'b1);
        a = rand_block();
        r = $random(seed);
        off = r[BR_OFF_W-1:0] | 12'h008;
        fo = 2'(r[31:16] % 16'd3);
        ent = '0;
        ent.en = 1'b1;
        ent.slot.en = 1'b1;
        ent.slot.offset = r[13:12];
        ent.slot.tar_state = TAR_OV;
        ent.slot.target = off;
        ent.fth_off = fo;
        // offset is in halfwords and TAR_OV bumps the bits above it by one
        tgt = (((a >> (BR_OFF_W + 1)) + 32'd1) << (BR_OFF_W + 1)) | {19'd0, off, 1'b0};
        fth = a + ((32'(fo) + 32'd1) * 32'd4);
        train_entry(a, ent, 1'b1, a + 32'd16);
        train_entry(a, ent, 1'b1, a + 32'd16);
        restart_at(a);
        check_pred("pred_o", pred_o, stage1_expect(a, a + 32'd16, 1'b1));
        next_cycle();
        settle();
        check_bit("redirect_o", redirect_o, 1'b1);
        check_pred("pred_o", pred_o,
                   redirect_expect(a, tgt, 1'b1, r[13:12], CONDITION, NONE));
        train_entry(a, ent, 1'b0, a + 32'd16);
        train_entry(a, ent, 1'b0, a + 32'd16);
        restart_at(a);
        next_cycle();
        settle();
        check_bit("redirect_o", redirect_o, 1'b1);
        check_pred("pred_o", pred_o, redirect_expect(a, fth, 1'b0, fo, CONDITION, NONE));
    endtask

    task automatic call_return();
        logic [VADDR_W-1:0] c;
        logic [VADDR_W-1:0] f;
        logic [VADDR_W-1:0] rb;
        logic [VADDR_W-1:0] ret_addr;
        logic [31:0] r;
        btb_entry_t call_ent;
        btb_entry_t ret_ent;
        reset_dut(1'b1);
        c = rand_block();
        r = $random(seed);
        f = c + 32'h200 + (r & 32'h0000_0FF0);
        rb = c + 32'h2010 + ((r >> 12) & 32'h0000_03E0);
        call_ent = '0;
        call_ent.en = 1'b1;
        call_ent.tail.en = 1'b1;
        call_ent.tail.offset = r[1:0];
        call_ent.tail.br_type = DIRECT;
        call_ent.tail.ras_type = PUSH;
        call_ent.tail.target.jump = f[20:1];
        call_ent.fth_off = 2'd3;
        ret_ent = '0;
        ret_ent.en = 1'b1;
        ret_ent.tail.en = 1'b1;
        ret_ent.tail.offset = r[3:2];
        ret_ent.tail.br_type = INDIRECT;
        ret_ent.tail.ras_type = POP;
        ret_ent.fth_off = 2'd3;
        ret_addr = c + (32'(r[1:0]) * 32'd4) + 32'd4;
        train_entry(c, call_ent, 1'b0, c + 32'd16);
        train_entry(rb, ret_ent, 1'b0, rb + 32'd16);
        restart_at(c);
        next_cycle();
        settle();
        check_bit("redirect_o", redirect_o, 1'b1);
        check_pred("pred_o", pred_o, redirect_expect(c, f, 1'b1, r[1:0], DIRECT, PUSH));
        restart_at(rb);
        next_cycle();
        settle();
        check_bit("redirect_o", redirect_o, 1'b1);
        check_pred("pred_o", pred_o,
                   redirect_expect(rb, ret_addr, 1'b1, r[3:2], INDIRECT, POP));
    endtask

    initial begin
        arst_n_i = 1'b0;
        stall_i = 1'b0;
        squash_i = 1'b0;
        squash_pc_i = '0;
        upd_i = '0;
        reset_and_step();
        squash_and_stall();
        direct_jump();
        cond_branch();
        call_return();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module branch_predictor #(
    parameter int UBTB_DEPTH = 16,
    parameter int BTB_DEPTH = 64,
    parameter int BHT_DEPTH = 128,
    parameter int RAS_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         arst_n_i,
    input  logic                         stall_i,
    input  logic                         squash_i,
    input  logic [bpu_pkg::VADDR_W-1:0]  squash_pc_i,
    input  bpu_pkg::update_t             upd_i,
    output bpu_pkg::pred_result_t        pred_o,
    output logic                         pred_valid_o,
    output logic                         redirect_o,
    output logic                         last_stage_o,
    output bpu_pkg::pred_result_t        last_stage_pred_o
);
    import bpu_pkg::*;

    logic [VADDR_W-1:0] pc;
    pred_result_t s1_result;
    pred_result_t s2_q;
    pred_result_t s2_in;
    pred_result_t s2_result;
    btb_entry_t btb_entry;
    logic dir_taken;
    logic ras_push, ras_pop, ras_valid;
    logic [VADDR_W-1:0] ras_push_addr, ras_top;
    logic s2_redirect;

    micro_btb #(.UBTB_DEPTH(UBTB_DEPTH)) u_micro_btb (
        .clk(clk), .arst_n_i(arst_n_i), .pc_i(pc), .upd_i(upd_i), .result_o(s1_result)
    );

    btb #(.BTB_DEPTH(BTB_DEPTH)) u_btb (
        .clk(clk), .arst_n_i(arst_n_i), .rd_en_i(!stall_i), .pc_i(pc),
        .upd_i(upd_i), .entry_o(btb_entry)
    );

    bimodal_dir #(.BHT_DEPTH(BHT_DEPTH)) u_bimodal_dir (
        .clk(clk), .arst_n_i(arst_n_i), .rd_en_i(!stall_i), .pc_i(pc),
        .upd_i(upd_i), .taken_o(dir_taken)
    );

    return_stack #(.RAS_DEPTH(RAS_DEPTH)) u_return_stack (
        .clk(clk), .arst_n_i(arst_n_i), .push_i(ras_push), .pop_i(ras_pop),
        .push_addr_i(ras_push_addr), .top_o(ras_top), .valid_o(ras_valid)
    );

    // a stalled or squashed block must not move the ras or redirect
    always_comb begin
        s2_in = s2_q;
        s2_in.en = s2_q.en && !stall_i && !squash_i;
    end

    s2_control #(.BTB_DEPTH(BTB_DEPTH)) u_s2_control (
        .result_i(s2_in), .entry_i(btb_entry), .dir_taken_i(dir_taken),
        .ras_top_i(ras_top), .ras_valid_i(ras_valid), .ras_push_o(ras_push),
        .ras_pop_o(ras_pop), .ras_push_addr_o(ras_push_addr), .result_o(s2_result)
    );

    assign s2_redirect = s2_result.en && s2_result.redirect;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc <= RESET_PC;
            s2_q <= '0;
        end else if (squash_i) begin
            pc <= squash_pc_i;
            s2_q <= '0;
        end else if (s2_redirect) begin
            // drop the wrong-path stage 1 block
            pc <= s2_result.target;
            s2_q <= '0;
        end else if (!stall_i) begin
            pc <= s1_result.target;
            s2_q <= s1_result;
        end
    end

    assign pred_o = s2_redirect ? s2_result : s1_result;
    assign pred_valid_o = pred_o.en && !squash_i && !stall_i;
    assign redirect_o = s2_redirect && !squash_i;
    assign last_stage_o = s2_result.en && !squash_i;
    assign last_stage_pred_o = s2_result;

endmodule

`default_nettype wire

//--- hw/s2_control.sv
`timescale 1ns/1ps
`default_nettype none

module s2_control #(
    parameter int BTB_DEPTH = 64
) (
    input  bpu_pkg::pred_result_t        result_i,
    input  bpu_pkg::btb_entry_t          entry_i,
    input  logic                         dir_taken_i,
    input  logic [bpu_pkg::VADDR_W-1:0]  ras_top_i,
    input  logic                         ras_valid_i,
    output logic                         ras_push_o,
    output logic                         ras_pop_o,
    output logic [bpu_pkg::VADDR_W-1:0]  ras_push_addr_o,
    output bpu_pkg::pred_result_t        result_o
);
    import bpu_pkg::*;

    localparam int IDX_W = $clog2(BTB_DEPTH);
    localparam int JMP_W = $bits(slot_target_u);

    // high part of base above lsb adjusted by st
    function automatic logic [VADDR_W-1:0] high_part(input logic [VADDR_W-1:0] base,
                                                     input tar_state_e st,
                                                     input int lsb);
        logic [VADDR_W-1:0] hi;
        hi = base >> lsb;
        case (st)
            TAR_OV: hi = hi + 1'b1;
            TAR_UN: hi = hi - 1'b1;
            default: ;
        endcase
        return hi << lsb;
    endfunction

    logic [VADDR_W-1:0] pc;
    logic hit;
    logic slot_taken, tail_cond_taken, cond_taken, jump_taken;
    logic [BR_OFF_W-1:0] cond_off;
    tar_state_e cond_tar;
    logic [SLOT_OFF_W-1:0] cond_size;
    logic [VADDR_W-1:0] br_target, jump_target, fth_target, predict_pc;
    logic ras_active;

    assign pc = result_i.start_addr;
    assign hit = entry_i.en && (entry_i.tag == pc[BLOCK_LSB + IDX_W +: BTB_TAG_W]);

    assign slot_taken = entry_i.slot.en && dir_taken_i;
    assign tail_cond_taken = entry_i.tail.en && entry_i.tail.br_type == CONDITION &&
                             !entry_i.slot.en && dir_taken_i;
    assign cond_taken = slot_taken || tail_cond_taken;
    assign jump_taken = entry_i.tail.en && entry_i.tail.br_type != CONDITION;

    assign cond_off = slot_taken ? entry_i.slot.target : entry_i.tail.target.cond.off;
    assign cond_tar = slot_taken ? entry_i.slot.tar_state : entry_i.tail.target.cond.tar_state;
    assign cond_size = slot_taken ? entry_i.slot.offset : entry_i.tail.offset;

    assign br_target = high_part(pc, cond_tar, BR_OFF_W + 1) | VADDR_W'({cond_off, 1'b0});
    assign jump_target = (entry_i.tail.ras_type == POP && ras_valid_i) ? ras_top_i :
                         high_part(pc, TAR_NONE, JMP_W + 1) |
                         VADDR_W'({entry_i.tail.target.jump, 1'b0});
    assign fth_target = pc + ((VADDR_W'(entry_i.fth_off) + 1'b1) << 2);
    assign predict_pc = cond_taken ? br_target : jump_taken ? jump_target : fth_target;

    // ras moves only for a taken tail jump of a live block
    assign ras_active = result_i.en && hit && jump_taken && !cond_taken;
    assign ras_push_o = ras_active && entry_i.tail.ras_type == PUSH;
    assign ras_pop_o = ras_active && entry_i.tail.ras_type == POP;
    assign ras_push_addr_o = pc + VADDR_W'({entry_i.tail.offset, 2'b00}) + 32'd4;

    always_comb begin
        result_o = result_i;
        if (hit && predict_pc != result_i.target) begin
            result_o.target = predict_pc;
            result_o.taken = cond_taken || jump_taken;
            result_o.size = cond_taken ? cond_size :
                            jump_taken ? entry_i.tail.offset : entry_i.fth_off;
            result_o.br_type = cond_taken ? CONDITION : entry_i.tail.br_type;
            result_o.ras_type = entry_i.tail.ras_type;
            result_o.redirect = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hw/return_stack.sv
`timescale 1ns/1ps
`default_nettype none

module return_stack #(
    parameter int RAS_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         arst_n_i,
    input  logic                         push_i,
    input  logic                         pop_i,
    input  logic [bpu_pkg::VADDR_W-1:0]  push_addr_i,
    output logic [bpu_pkg::VADDR_W-1:0]  top_o,
    output logic                         valid_o
);
    import bpu_pkg::*;

    localparam int PTR_W = $clog2(RAS_DEPTH);

    logic [VADDR_W-1:0] stack [RAS_DEPTH];
    // next free slot
    logic [PTR_W-1:0] ptr;
    logic [PTR_W-1:0] top_idx;
    logic [PTR_W:0] cnt;

    assign top_idx = ptr - 1'b1;
    assign top_o = stack[top_idx];
    assign valid_o = (cnt != '0);

    // pointer wraps, so a push when full drops the oldest entry
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ptr <= '0;
            cnt <= '0;
        end else if (push_i) begin
            ptr <= ptr + 1'b1;
            if (cnt != (PTR_W + 1)'(RAS_DEPTH)) begin
                cnt <= cnt + 1'b1;
            end
        end else if (pop_i && valid_o) begin
            ptr <= top_idx;
            cnt <= cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            stack[ptr] <= push_addr_i;
        end
    end

endmodule

`default_nettype wire

//--- hw/bimodal_dir.sv
`timescale 1ns/1ps
`default_nettype none

module bimodal_dir #(
    parameter int BHT_DEPTH = 128
) (
    input  logic                         clk,
    input  logic                         arst_n_i,
    input  logic                         rd_en_i,
    input  logic [bpu_pkg::VADDR_W-1:0]  pc_i,
    input  bpu_pkg::update_t             upd_i,
    output logic                         taken_o
);
    import bpu_pkg::*;

    localparam int IDX_W = $clog2(BHT_DEPTH);

    logic [1:0] ctr [BHT_DEPTH];
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic train;

    assign rd_idx = pc_i[BLOCK_LSB +: IDX_W];
    assign wr_idx = upd_i.start_addr[BLOCK_LSB +: IDX_W];
    // tail conditional shares the block counter
    assign train = upd_i.valid && (upd_i.entry.slot.en ||
                   (upd_i.entry.tail.en && upd_i.entry.tail.br_type == CONDITION));

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            // weakly not-taken
            for (int i = 0; i < BHT_DEPTH; i++) begin
                ctr[i] <= 2'b01;
            end
        end else if (train) begin
            if (upd_i.cond_taken && ctr[wr_idx] != 2'b11) begin
                ctr[wr_idx] <= ctr[wr_idx] + 2'd1;
            end else if (!upd_i.cond_taken && ctr[wr_idx] != 2'b00) begin
                ctr[wr_idx] <= ctr[wr_idx] - 2'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            taken_o <= 1'b0;
        end else if (rd_en_i) begin
            taken_o <= ctr[rd_idx][1];
        end
    end

endmodule

`default_nettype wire

//--- hw/btb.sv
`timescale 1ns/1ps
`default_nettype none

module btb #(
    parameter int BTB_DEPTH = 64
) (
    input  logic                         clk,
    input  logic                         arst_n_i,
    input  logic                         rd_en_i,
    input  logic [bpu_pkg::VADDR_W-1:0]  pc_i,
    input  bpu_pkg::update_t             upd_i,
    output bpu_pkg::btb_entry_t          entry_o
);
    import bpu_pkg::*;

    localparam int IDX_W = $clog2(BTB_DEPTH);

    logic [BTB_DEPTH-1:0] vld;
    btb_entry_t mem [BTB_DEPTH];
    btb_entry_t wr_entry;
    btb_entry_t rd_entry;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    assign rd_idx = pc_i[BLOCK_LSB +: IDX_W];
    assign wr_idx = upd_i.start_addr[BLOCK_LSB +: IDX_W];

    // tag is taken from the block address above the index
    always_comb begin
        wr_entry = upd_i.entry;
        wr_entry.tag = upd_i.start_addr[BLOCK_LSB + IDX_W +: BTB_TAG_W];
    end

    always_comb begin
        rd_entry = mem[rd_idx];
        rd_entry.en = vld[rd_idx] && mem[rd_idx].en;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            vld <= '0;
        end else if (upd_i.valid) begin
            vld[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (upd_i.valid) begin
            mem[wr_idx] <= wr_entry;
        end
    end

    // read port holds while fetch is stalled
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            entry_o <= '0;
        end else if (rd_en_i) begin
            entry_o <= rd_entry;
        end
    end

endmodule

`default_nettype wire

//--- hw/micro_btb.sv
`timescale 1ns/1ps
`default_nettype none

module micro_btb #(
    parameter int UBTB_DEPTH = 16
) (
    input  logic                         clk,
    input  logic                         arst_n_i,
    input  logic [bpu_pkg::VADDR_W-1:0]  pc_i,
    input  bpu_pkg::update_t             upd_i,
    output bpu_pkg::pred_result_t        result_o
);
    import bpu_pkg::*;

    localparam int IDX_W = $clog2(UBTB_DEPTH);

    logic [UBTB_DEPTH-1:0] vld;
    logic [VADDR_W-1:0] tag_mem [UBTB_DEPTH];
    logic [VADDR_W-1:0] tgt_mem [UBTB_DEPTH];
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic hit;

    assign rd_idx = pc_i[BLOCK_LSB +: IDX_W];
    assign wr_idx = upd_i.start_addr[BLOCK_LSB +: IDX_W];
    // full address compare avoids aliasing
    assign hit = vld[rd_idx] && (tag_mem[rd_idx] == pc_i);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            vld <= '0;
        end else if (upd_i.valid) begin
            vld[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (upd_i.valid) begin
            tag_mem[wr_idx] <= upd_i.start_addr;
            tgt_mem[wr_idx] <= upd_i.taken_target;
        end
    end

    always_comb begin
        result_o.en = 1'b1;
        result_o.start_addr = pc_i;
        result_o.target = hit ? tgt_mem[rd_idx] : pc_i + VADDR_W'(BLOCK_BYTES);
        result_o.taken = hit;
        result_o.size = '1;
        result_o.br_type = DIRECT;
        result_o.ras_type = NONE;
        result_o.redirect = 1'b0;
    end

endmodule

`default_nettype wire

//--- hw/bpu_pkg.sv
`default_nettype none

package bpu_pkg;

    localparam int VADDR_W = 32;
    localparam int BLOCK_BYTES = 16;
    localparam int BLOCK_LSB = $clog2(BLOCK_BYTES);
    localparam int SLOT_OFF_W = 2;
    localparam int BTB_TAG_W = 8;
    // halfword units
    localparam int BR_OFF_W = 12;
    localparam logic [VADDR_W-1:0] RESET_PC = 32'h0000_1000;

    typedef enum logic [1:0] {
        CONDITION,
        DIRECT,
        INDIRECT
    } br_type_e;

    typedef enum logic [1:0] {
        NONE,
        PUSH,
        POP
    } ras_type_e;

    // whether high target bits match the block pc or differ by one
    typedef enum logic [1:0] {
        TAR_NONE,
        TAR_OV,
        TAR_UN
    } tar_state_e;

    typedef struct packed {
        logic [5:0] rsvd;
        tar_state_e tar_state;
        logic [BR_OFF_W-1:0] off;
    } cond_target_t;

    // tail slot target as decoded by br_type
    typedef union packed {
        cond_target_t cond;
        logic [19:0] jump;
    } slot_target_u;

    typedef struct packed {
        logic en;
        logic [SLOT_OFF_W-1:0] offset;
        tar_state_e tar_state;
        logic [BR_OFF_W-1:0] target;
    } btb_slot_t;

    typedef struct packed {
        logic en;
        logic [SLOT_OFF_W-1:0] offset;
        br_type_e br_type;
        ras_type_e ras_type;
        slot_target_u target;
    } btb_tail_t;

    typedef struct packed {
        logic en;
        logic [BTB_TAG_W-1:0] tag;
        btb_slot_t slot;
        btb_tail_t tail;
        logic [SLOT_OFF_W-1:0] fth_off;
    } btb_entry_t;

    typedef struct packed {
        logic en;
        logic [VADDR_W-1:0] start_addr;
        logic [VADDR_W-1:0] target;
        logic taken;
        logic [SLOT_OFF_W-1:0] size;
        br_type_e br_type;
        ras_type_e ras_type;
        logic redirect;
    } pred_result_t;

    typedef struct packed {
        logic valid;
        logic [VADDR_W-1:0] start_addr;
        btb_entry_t entry;
        logic cond_taken;
        logic [VADDR_W-1:0] taken_target;
    } update_t;

endpackage

`default_nettype wire
